// File: bench/tb_clock.sv
module tb_clock (
    output logic clk,
    output logic rst_n
);
    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk; // 4 ns period
    end

    initial begin
        rst_n = 1'b0;
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
    end

endmodule

// File: bench/tb_vstore.sv
`include "vstore_consts.svh"

module tb_vstore;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int WAIT_LIMIT = 400;

    logic clk;
    logic rst_n;
    vstore_pkg::vreg_t vreg;
    vstore_pkg::addr_t addr;
    vstore_pkg::vlen_t vlen;
    logic write_start;
    logic sdram_credit;
    logic busy;
    logic write_done;
    logic sdram_write;
    vstore_pkg::addr_t sdram_address;
    vstore_pkg::beat_t sdram_writedata;
    vstore_pkg::byte_en_t sdram_byteenable;

    logic [31:0] lfsr_state = 32'hfe05;
    logic timed_out = 1'b0;
    int cycle_no = 0;
    int credit_due[$];

    tb_clock i_clock (.*);
    vstore_top i_vstore_top (.*);
    vstore_checker i_checker (.*);

    // Galois shift, one step for every bit drawn
    function automatic logic [31:0] random_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = {1'b0, lfsr_state[31:1]} ^ (lfsr_state[0] ? 32'h8020_0003 : 32'h0);
            r[i] = lfsr_state[0];
        end
        return r;
    endfunction

    function automatic vstore_pkg::vreg_t random_vreg();
        vstore_pkg::vreg_t v;
        for (int w = 0; w < `VS_VREG_W / 32; w++)
            v[32 * w +: 32] = random_bits(32);
        return v;
    endfunction

    function automatic vstore_pkg::addr_t random_addr();
        return random_bits(28) << 4; // aligned to a beat
    endfunction

    function automatic vstore_pkg::vlen_t random_vlen();
        return vstore_pkg::vlen_t'(1 + random_bits(8) % (`VS_BEATS * `VS_BEAT_BYTES));
    endfunction

    // each strobe comes back as one credit pulse 0 to 7 cycles later
    always @(posedge clk) begin : credit_return
        int pick;
        pick = -1;
        cycle_no++;
        if (!rst_n) begin
            credit_due.delete();
            sdram_credit <= 1'b0;
        end else begin
            if (sdram_write)
                credit_due.push_back(cycle_no + int'(random_bits(3)));
            foreach (credit_due[i])
                if (pick < 0 && credit_due[i] <= cycle_no)
                    pick = i;
            if (pick >= 0)
                credit_due.delete(pick); // colliding returns slip by a cycle
            sdram_credit <= (pick >= 0);
        end
    end

    task automatic wait_for(input bit on_done, input logic level, input string what);
        int n;
        n = 0;
        @(posedge clk);
        while ((on_done ? write_done : busy) !== level && n < WAIT_LIMIT) begin
            @(posedge clk);
            n++;
        end
        if ((on_done ? write_done : busy) !== level) begin
            $display("timeout: %s did not happen within %0d cycles", what, WAIT_LIMIT);
            timed_out = 1'b1;
        end
    endtask

    task automatic issue_store(input vstore_pkg::vreg_t v, input vstore_pkg::addr_t a,
                               input vstore_pkg::vlen_t l);
        @(posedge clk);
        vreg <= v;
        addr <= a;
        vlen <= l;
        write_start <= 1'b1;
        @(posedge clk);
        write_start <= 1'b0;
    endtask

    task automatic store(input vstore_pkg::vreg_t v, input vstore_pkg::addr_t a,
                         input vstore_pkg::vlen_t l);
        wait_for(0, 1'b0, "busy falling");
        if (!timed_out) begin
            issue_store(v, a, l);
            wait_for(1, 1'b1, "write_done rising");
            @(posedge clk);
        end
    endtask

    initial begin
        vstore_pkg::vlen_t edge_lens[6];
        edge_lens = '{8'd1, 8'd15, 8'd16, 8'd17, 8'd160, 8'd175};
        vreg <= '0;
        addr <= '0;
        vlen <= 8'd1;
        write_start <= 1'b0;
        sdram_credit <= 1'b0;
        i_checker.start_test("reset");
        repeat (5) @(posedge clk);
        i_checker.finish_test();
        if (!timed_out) begin
            i_checker.start_test("full_store");
            store(random_vreg(), random_addr(), 8'd176);
            i_checker.finish_test();
        end
        if (!timed_out) begin
            i_checker.start_test("random_partial");
            foreach (edge_lens[i])
                if (!timed_out) store(random_vreg(), random_addr(), edge_lens[i]);
            for (int i = 0; i < 16 && !timed_out; i++)
                store(random_vreg(), random_addr(), random_vlen());
            i_checker.finish_test();
        end
        if (!timed_out) begin
            i_checker.start_test("credit_backpressure");
            for (int i = 0; i < 6 && !timed_out; i++)
                store(random_vreg(), random_addr(), 8'd176);
            i_checker.finish_test();
        end
        if (!timed_out) begin
            i_checker.start_test("done_busy");
            for (int i = 0; i < 4 && !timed_out; i++)
                store(random_vreg(), random_addr(), random_vlen());
            i_checker.finish_test();
        end
        if (!timed_out) begin
            i_checker.start_test("start_while_busy");
            wait_for(0, 1'b0, "busy falling");
            issue_store(random_vreg(), random_addr(), 8'd176);
            wait_for(0, 1'b1, "busy rising");
            issue_store(random_vreg(), random_addr(), random_vlen());
            wait_for(1, 1'b1, "write_done rising");
            repeat (30) @(posedge clk); // any strobe from the dropped start shows up here
            i_checker.finish_test();
        end
        $display("tests run %0d, failed %0d, errors %0d", i_checker.tests_run,
                 i_checker.tests_failed, i_checker.total_errors);
        if (timed_out || i_checker.total_errors != 0)
            $display("TESTS FAILED");
        else
            $display("TESTS PASSED");
        $finish;
    end

endmodule

// File: bench/vstore_checker.sv
`include "vstore_consts.svh"

module vstore_checker (
    input logic clk,
    input logic rst_n,
    input vstore_pkg::vreg_t vreg,
    input vstore_pkg::addr_t addr,
    input vstore_pkg::vlen_t vlen,
    input logic write_start,
    input logic busy,
    input logic write_done,
    input logic sdram_credit,
    input logic sdram_write,
    input vstore_pkg::addr_t sdram_address,
    input vstore_pkg::beat_t sdram_writedata,
    input vstore_pkg::byte_en_t sdram_byteenable
);
    timeunit 1ns;
    timeprecision 100ps;

    string test_name = "reset";
    int tests_run = 0;
    int tests_failed = 0;
    int total_errors = 0;
    int test_errors = 0;
    int beat_no = 0;
    int outstanding = 0;
    vstore_pkg::addr_t exp_addr[$];
    vstore_pkg::beat_t exp_data[$];
    vstore_pkg::byte_en_t exp_be[$];
    logic after_reset = 1'b0;
    logic after_accept = 1'b0;
    logic done_due = 1'b0;
    logic prev_busy = 1'b0;
    logic prev_done = 1'b0;

    task automatic start_test(input string name);
        test_name = name;
        test_errors = 0;
    endtask

    task automatic mismatch(input string what, input logic [127:0] expected,
                            input logic [127:0] actual);
        $display("FAILED %s %s: expected 0x%0h, actual 0x%0h", test_name, what, expected, actual);
        test_errors++;
        total_errors++;
    endtask

    task automatic problem(input string what);
        $display("ERROR in %s: %s", test_name, what);
        test_errors++;
        total_errors++;
    endtask

    task automatic finish_test();
        @(negedge clk); // the sampling at the rising edge is over by now
        if (exp_addr.size() != 0)
            problem($sformatf("%0d beats were never written to memory", exp_addr.size()));
        tests_run++;
        if (test_errors != 0)
            tests_failed++;
        $display("test %s: %s, %0d errors", test_name, (test_errors == 0) ? "ok" : "bad",
                 test_errors);
    endtask

    // beat k lands at addr + 16k and only the tail of the last beat is masked
    task automatic expect_request(input vstore_pkg::vreg_t v, input vstore_pkg::addr_t a,
                                  input int len);
        int beats;
        int tail;
        beats = (len + `VS_BEAT_BYTES - 1) / `VS_BEAT_BYTES;
        tail = len - `VS_BEAT_BYTES * (beats - 1);
        for (int k = 0; k < beats; k++) begin
            exp_addr.push_back(a + `VS_BEAT_BYTES * k);
            exp_data.push_back(v[`VS_BEAT_W * k +: `VS_BEAT_W]);
            exp_be.push_back((k < beats - 1) ? 16'hffff : 16'((32'd1 << tail) - 1));
        end
    endtask

    always @(posedge clk) begin
        if (!rst_n) begin
            exp_addr.delete();
            exp_data.delete();
            exp_be.delete();
            outstanding = 0;
            after_reset = 1'b1;
            after_accept = 1'b0;
            done_due = 1'b0;
            prev_busy = 1'b0;
            prev_done = 1'b0;
        end else begin
            if (after_reset) begin
                if (busy !== 1'b0) mismatch("busy after reset", 0, busy);
                if (write_done !== 1'b0) mismatch("write_done after reset", 0, write_done);
                if (sdram_write !== 1'b0) mismatch("sdram_write after reset", 0, sdram_write);
                after_reset = 1'b0;
            end
            if (after_accept) begin
                if (write_done !== 1'b0) mismatch("write_done after start", 0, write_done);
                if (busy !== 1'b1) mismatch("busy after start", 1, busy);
            end
            // done and the fall of busy belong to the cycle after the last strobe
            if (done_due) begin
                if (write_done !== 1'b1) mismatch("write_done after last beat", 1, write_done);
                if (busy !== 1'b0) mismatch("busy after last beat", 0, busy);
            end else begin
                if (write_done && !prev_done) problem("write_done rose before the last beat");
                if (!busy && prev_busy) problem("busy fell before the last beat");
            end
            if (busy && !prev_busy && !after_accept)
                problem("busy rose without an accepted start");
            done_due = 1'b0;
            after_accept = write_start && !busy;
            if (after_accept) begin
                if (exp_addr.size() != 0) problem("a start was accepted with beats pending");
                beat_no = 0;
                expect_request(vreg, addr, int'(vlen));
            end
            if (sdram_write) outstanding++;
            if (sdram_credit) outstanding--;
            if (outstanding > `VS_MEM_CREDITS)
                problem($sformatf("%0d memory writes outstanding", outstanding));
            if (sdram_write) begin
                if (exp_addr.size() == 0) begin
                    problem($sformatf("unexpected memory write to 0x%0h", sdram_address));
                end else begin
                    if (sdram_address !== exp_addr[0])
                        mismatch($sformatf("beat %0d address", beat_no), exp_addr[0],
                                 sdram_address);
                    if (sdram_writedata !== exp_data[0])
                        mismatch($sformatf("beat %0d data", beat_no), exp_data[0],
                                 sdram_writedata);
                    if (sdram_byteenable !== exp_be[0])
                        mismatch($sformatf("beat %0d byte enables", beat_no), exp_be[0],
                                 sdram_byteenable);
                    exp_addr.delete(0);
                    exp_data.delete(0);
                    exp_be.delete(0);
                    beat_no++;
                    done_due = (exp_addr.size() == 0);
                end
            end
            prev_busy = busy;
            prev_done = write_done;
        end
    end

endmodule

// File: files.f
+incdir+include
hw/vstore_pkg.sv
hw/vstore_capture.sv
hw/beat_sequencer.sv
hw/write_issue_queue.sv
hw/vstore_top.sv
bench/tb_clock.sv
bench/vstore_checker.sv
bench/tb_vstore.sv

// File: hw/beat_sequencer.sv
`default_nettype none

`include "vstore_consts.svh"

module beat_sequencer (
    input wire clk,
    input wire rst_n,

    // job from the capture stage
    input wire job_go,
    input wire vstore_pkg::vreg_t job_vreg,
    input wire vstore_pkg::addr_t job_addr,
    input wire vstore_pkg::vlen_t job_vlen,

    // credit return from the issue queue
    input wire q_credit,

    // beats towards the issue queue
    output logic beat_push,
    output vstore_pkg::beat_t beat_data,
    output vstore_pkg::addr_t beat_addr,
    output vstore_pkg::byte_en_t beat_be,
    output logic beat_last
);

    localparam int OFS_W = $clog2(`VS_BEAT_BYTES);

    vstore_pkg::seq_state_t state;
    vstore_pkg::beat_idx_t beat_idx;
    vstore_pkg::beat_idx_t last_idx;
    vstore_pkg::byte_en_t tail_be;
    vstore_pkg::byte_en_t tail_be_next;
    vstore_pkg::credit_t credits;
    logic [8:0] len_round;
    logic start_job;

    assign start_job = job_go && (state == vstore_pkg::SEQ_IDLE);

    // length rounded up to whole beats, one spare bit so 255 cannot wrap
    assign len_round = {1'b0, job_vlen} + 9'(`VS_BEAT_BYTES - 1);

    // a length that ends on a beat boundary keeps the last beat whole
    always_comb begin
        if (job_vlen[OFS_W-1:0] == '0)
            tail_be_next = '1;
        else
            tail_be_next = ~({`VS_BEAT_BYTES{1'b1}} << job_vlen[OFS_W-1:0]);
    end

    always_ff @(posedge clk) begin
        if (start_job) begin
            last_idx <= vstore_pkg::beat_idx_t'((len_round >> OFS_W) - 9'd1);
            tail_be <= tail_be_next;
        end
    end

    assign beat_push = (state == vstore_pkg::SEQ_RUN) && (credits != '0);
    assign beat_last = (beat_idx == last_idx);
    assign beat_be = beat_last ? tail_be : '1;
    assign beat_data = job_vreg[beat_idx * `VS_BEAT_W +: `VS_BEAT_W];

    always_ff @(posedge clk, negedge rst_n) begin
        if (!rst_n) begin
            state <= vstore_pkg::SEQ_IDLE;
            beat_idx <= '0;
        end else begin
            case (state)
                vstore_pkg::SEQ_IDLE: begin
                    if (start_job) begin
                        state <= vstore_pkg::SEQ_RUN;
                        beat_idx <= '0;
                    end
                end
                default: begin
                    // without a credit the position simply holds
                    if (beat_push) begin
                        if (beat_last)
                            state <= vstore_pkg::SEQ_IDLE;
                        else
                            beat_idx <= beat_idx + 4'd1;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (start_job)
            beat_addr <= job_addr;
        else if (beat_push)
            beat_addr <= beat_addr + `VS_BEAT_BYTES; // next 16 byte line
    end

    // one credit per free queue entry
    always_ff @(posedge clk, negedge rst_n) begin
        if (!rst_n) begin
            credits <= vstore_pkg::credit_t'(`VS_QUEUE_DEPTH);
        end else begin
            case ({beat_push, q_credit})
                2'b10: credits <= credits - 3'd1;
                2'b01: credits <= credits + 3'd1;
                default: credits <= credits;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: hw/vstore_capture.sv
`default_nettype none

module vstore_capture (
    input wire clk,
    input wire rst_n,

    // request side
    input wire vstore_pkg::vreg_t vreg,
    input wire vstore_pkg::addr_t addr,
    input wire vstore_pkg::vlen_t vlen,
    input wire write_start,
    output logic busy,
    output logic write_done,

    // from the issue queue
    input wire last_issued,

    // to the beat sequencer
    output logic job_go,
    output vstore_pkg::vreg_t job_vreg,
    output vstore_pkg::addr_t job_addr,
    output vstore_pkg::vlen_t job_vlen
);

    vstore_pkg::cap_state_t state;
    logic accept;

    // a start while a job is in flight is dropped here
    assign accept = write_start && (state == vstore_pkg::CAP_IDLE);

    assign busy = (state == vstore_pkg::CAP_BUSY);

    always_ff @(posedge clk, negedge rst_n) begin
        if (!rst_n) begin
            state <= vstore_pkg::CAP_IDLE;
        end else begin
            case (state)
                vstore_pkg::CAP_IDLE: begin
                    if (accept)
                        state <= vstore_pkg::CAP_BUSY;
                end
                default: begin
                    if (last_issued) // busy drops with done rising
                        state <= vstore_pkg::CAP_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk, negedge rst_n) begin
        if (!rst_n)
            job_go <= 1'b0;
        else
            job_go <= accept;
    end

    // done is sticky until the next accepted request
    always_ff @(posedge clk, negedge rst_n) begin
        if (!rst_n)
            write_done <= 1'b0;
        else if (accept)
            write_done <= 1'b0;
        else if (last_issued)
            write_done <= 1'b1;
    end

    // snapshot stays put until the job completes
    always_ff @(posedge clk) begin
        if (accept) begin
            job_vreg <= vreg;
            job_addr <= addr;
            job_vlen <= vlen;
        end
    end

endmodule

`default_nettype wire

// File: hw/vstore_pkg.sv
`include "vstore_consts.svh"

package vstore_pkg;

    typedef logic [`VS_VREG_W-1:0] vreg_t;
    typedef logic [`VS_BEAT_W-1:0] beat_t;
    typedef logic [31:0] addr_t;
    typedef logic [`VS_BEAT_BYTES-1:0] byte_en_t;

    // length in bytes, 1 up to 176
    typedef logic [7:0] vlen_t;

    typedef logic [3:0] beat_idx_t;
    typedef logic [2:0] credit_t;

    typedef enum logic {
        SEQ_IDLE,
        SEQ_RUN
    } seq_state_t;

    typedef enum logic {
        CAP_IDLE,
        CAP_BUSY
    } cap_state_t;

endpackage

// File: hw/vstore_top.sv
`default_nettype none

module vstore_top (
    input wire clk,
    input wire rst_n,

    // request side
    input wire vstore_pkg::vreg_t vreg,
    input wire vstore_pkg::addr_t addr,
    input wire vstore_pkg::vlen_t vlen,
    input wire write_start,
    output logic busy,
    output logic write_done,

    // memory write port
    input wire sdram_credit,
    output logic sdram_write,
    output vstore_pkg::addr_t sdram_address,
    output vstore_pkg::beat_t sdram_writedata,
    output vstore_pkg::byte_en_t sdram_byteenable
);

    logic job_go;
    vstore_pkg::vreg_t job_vreg;
    vstore_pkg::addr_t job_addr;
    vstore_pkg::vlen_t job_vlen;

    logic beat_push;
    vstore_pkg::beat_t beat_data;
    vstore_pkg::addr_t beat_addr;
    vstore_pkg::byte_en_t beat_be;
    logic beat_last;
    logic q_credit;
    logic last_issued;

    vstore_capture i_capture (
        .clk         (clk),
        .rst_n       (rst_n),
        .vreg        (vreg),
        .addr        (addr),
        .vlen        (vlen),
        .write_start (write_start),
        .busy        (busy),
        .write_done  (write_done),
        .last_issued (last_issued),
        .job_go      (job_go),
        .job_vreg    (job_vreg),
        .job_addr    (job_addr),
        .job_vlen    (job_vlen)
    );

    beat_sequencer i_sequencer (
        .clk       (clk),
        .rst_n     (rst_n),
        .job_go    (job_go),
        .job_vreg  (job_vreg),
        .job_addr  (job_addr),
        .job_vlen  (job_vlen),
        .q_credit  (q_credit),
        .beat_push (beat_push),
        .beat_data (beat_data),
        .beat_addr (beat_addr),
        .beat_be   (beat_be),
        .beat_last (beat_last)
    );

    write_issue_queue i_queue (
        .clk              (clk),
        .rst_n            (rst_n),
        .beat_push        (beat_push),
        .beat_data        (beat_data),
        .beat_addr        (beat_addr),
        .beat_be          (beat_be),
        .beat_last        (beat_last),
        .q_credit         (q_credit),
        .last_issued      (last_issued),
        .sdram_credit     (sdram_credit),
        .sdram_write      (sdram_write),
        .sdram_address    (sdram_address),
        .sdram_writedata  (sdram_writedata),
        .sdram_byteenable (sdram_byteenable)
    );

endmodule

`default_nettype wire

// File: hw/write_issue_queue.sv
`default_nettype none

`include "vstore_consts.svh"

module write_issue_queue (
    input wire clk,
    input wire rst_n,

    // beats from the sequencer
    input wire beat_push,
    input wire vstore_pkg::beat_t beat_data,
    input wire vstore_pkg::addr_t beat_addr,
    input wire vstore_pkg::byte_en_t beat_be,
    input wire beat_last,
    output logic q_credit,

    // end of job towards the capture stage
    output logic last_issued,

    // memory write port
    input wire sdram_credit,
    output logic sdram_write,
    output vstore_pkg::addr_t sdram_address,
    output vstore_pkg::beat_t sdram_writedata,
    output vstore_pkg::byte_en_t sdram_byteenable
);

    localparam int PTR_W = $clog2(`VS_QUEUE_DEPTH);

    vstore_pkg::beat_t data_q [`VS_QUEUE_DEPTH];
    vstore_pkg::addr_t addr_q [`VS_QUEUE_DEPTH];
    vstore_pkg::byte_en_t be_q [`VS_QUEUE_DEPTH];
    logic last_q [`VS_QUEUE_DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    vstore_pkg::credit_t count;
    vstore_pkg::credit_t mem_credits;

    vstore_pkg::beat_t head_data;
    vstore_pkg::addr_t head_addr;
    vstore_pkg::byte_en_t head_be;
    logic head_last;
    logic empty;
    logic pop;

    assign empty = (count == '0);

    // an empty queue passes the incoming beat straight to the output register
    always_comb begin
        if (empty) begin
            head_data = beat_data;
            head_addr = beat_addr;
            head_be = beat_be;
            head_last = beat_last;
        end else begin
            head_data = data_q[rd_ptr];
            head_addr = addr_q[rd_ptr];
            head_be = be_q[rd_ptr];
            head_last = last_q[rd_ptr];
        end
    end

    assign pop = (!empty || beat_push) && (mem_credits != '0);

    always_ff @(posedge clk) begin
        if (beat_push) begin
            data_q[wr_ptr] <= beat_data;
            addr_q[wr_ptr] <= beat_addr;
            be_q[wr_ptr] <= beat_be;
            last_q[wr_ptr] <= beat_last;
        end
    end

    always_ff @(posedge clk, negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else begin
            if (beat_push)
                wr_ptr <= (wr_ptr == PTR_W'(`VS_QUEUE_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            if (pop)
                rd_ptr <= (rd_ptr == PTR_W'(`VS_QUEUE_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            case ({beat_push, pop})
                2'b10: count <= count + 3'd1;
                2'b01: count <= count - 3'd1;
                default: count <= count;
            endcase
        end
    end

    // a returned credit and a new strobe in one cycle cancel out
    always_ff @(posedge clk, negedge rst_n) begin
        if (!rst_n) begin
            mem_credits <= vstore_pkg::credit_t'(`VS_MEM_CREDITS);
        end else begin
            case ({pop, sdram_credit})
                2'b10: mem_credits <= mem_credits - 3'd1;
                2'b01: begin
                    if (mem_credits < vstore_pkg::credit_t'(`VS_MEM_CREDITS))
                        mem_credits <= mem_credits + 3'd1;
                end
                default: mem_credits <= mem_credits;
            endcase
        end
    end

    always_ff @(posedge clk, negedge rst_n) begin
        if (!rst_n) begin
            sdram_write <= 1'b0;
            q_credit <= 1'b0;
            last_issued <= 1'b0;
        end else begin
            sdram_write <= pop;
            q_credit <= pop; // the entry leaving frees a slot upstream
            last_issued <= pop && head_last;
        end
    end

    always_ff @(posedge clk) begin
        if (pop) begin
            sdram_address <= head_addr;
            sdram_writedata <= head_data;
            sdram_byteenable <= head_be;
        end
    end

endmodule

`default_nettype wire

// File: include/vstore_consts.svh
`ifndef VSTORE_CONSTS_SVH
`define VSTORE_CONSTS_SVH

// one memory beat and the vector register it is cut from
`define VS_BEAT_W 128
`define VS_VREG_W 1408

// a full register is VS_VREG_W / VS_BEAT_W beats
`define VS_BEATS 11

// address step between consecutive beats
`define VS_BEAT_BYTES 16

// issue queue entries, also the credits the sequencer starts with
`define VS_QUEUE_DEPTH 4

// write credits granted by the memory after reset
`define VS_MEM_CREDITS 4

`endif
